// File: common/data_port_if.sv
`timescale 1ns/10ps
`default_nettype none

// single read/write port of the data array
interface data_port_if;

    logic                   en;
    dcache_pkg::strobe_t    strobe;
    dcache_pkg::data_addr_t addr;
    dcache_pkg::word_t      wdata;
    dcache_pkg::word_t      rdata;

    modport ctrl (
        output en,
        output strobe,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  en,
        input  strobe,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // 16KB, 2-way, 128 sets, 16 words per line
    localparam int word_width     = 32;
    localparam int bytes_per_word = 4;
    localparam int byte_width     = word_width / bytes_per_word;
    localparam int words_per_line = 16;
    localparam int num_ways       = 2;
    localparam int num_sets       = 128;

    localparam int offset_bits = $clog2(words_per_line);
    localparam int index_bits  = $clog2(num_sets);
    localparam int align_bits  = $clog2(bytes_per_word);
    localparam int way_bits    = $clog2(num_ways);
    localparam int tag_bits    = 32 - index_bits - offset_bits - align_bits;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [bytes_per_word-1:0] strobe_t;
    typedef logic [offset_bits-1:0]    offset_t;
    typedef logic [index_bits-1:0]     index_t;
    typedef logic [tag_bits-1:0]       tag_t;
    typedef logic [way_bits-1:0]       way_t;
    typedef logic [align_bits-1:0]     align_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        align_t  align;
    } addr_t;

    // word location inside the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } data_addr_t;

    typedef enum logic [1:0] {
        idle,
        wb_read,
        wb_send,
        fill
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: dcache/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req_valid,
    input  addr_t       req_addr,
    input  strobe_t     req_strobe,
    input  word_t       req_wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    input  logic        hit,
    input  way_t        hit_way,
    input  way_t        victim_way,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    output logic        meta_fill,
    output logic        meta_touch,
    output logic        write_hit,
    output logic        lookup_en,
    output logic        burst_step,
    output logic        burst_clear,
    input  offset_t     burst_count,
    input  logic        burst_last,
    output logic        buf_capture,
    input  word_t       buf_word,
    output logic        mem_valid,
    output logic        mem_is_write,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    input  logic        mem_ready,
    input  logic        mem_last,
    input  word_t       mem_rdata,
    data_port_if.ctrl   data_port
);

    ctrl_state_t state;
    logic        lk_valid;
    addr_t       lk_addr;
    strobe_t     lk_strobe;
    word_t       lk_wdata;
    logic        wb_tail;
    logic        lk_hit;
    logic        lk_miss;

    // only one request sits in lookup at a time
    assign lookup_en = (state == idle) && req_valid && !lk_valid;
    assign lk_hit    = (state == idle) && lk_valid && hit;
    assign lk_miss   = (state == idle) && lk_valid && !hit;

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            lk_addr   <= req_addr;
            lk_strobe <= req_strobe;
            lk_wdata  <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state    <= idle;
            lk_valid <= 1'b0;
            wb_tail  <= 1'b0;
            data_ok  <= 1'b0;
        end else begin
            lk_valid <= lookup_en;
            data_ok  <= addr_ok;
            unique case (state)
                idle: begin
                    if (lk_miss) begin
                        state <= victim_dirty ? wb_read : fill;
                    end
                end
                wb_read: begin
                    // one extra cycle to capture the last word read
                    if (burst_last) begin
                        wb_tail <= 1'b1;
                    end
                    if (wb_tail) begin
                        wb_tail <= 1'b0;
                        state   <= wb_send;
                    end
                end
                wb_send: begin
                    if (mem_ready && mem_last) begin
                        state <= fill;
                    end
                end
                fill: begin
                    // back to idle where the held request is looked up again
                    if (mem_ready && mem_last) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_comb begin
        data_port.en          = 1'b0;
        data_port.strobe      = '0;
        data_port.addr.way    = victim_way;
        data_port.addr.index  = lk_addr.index;
        data_port.addr.offset = burst_count;
        data_port.wdata       = mem_rdata;
        burst_step            = 1'b0;
        buf_capture           = 1'b0;
        unique case (state)
            idle: begin
                if (lk_hit) begin
                    data_port.en          = 1'b1;
                    data_port.strobe      = lk_strobe;
                    data_port.addr.way    = hit_way;
                    data_port.addr.offset = lk_addr.offset;
                    data_port.wdata       = lk_wdata;
                end
            end
            wb_read: begin
                data_port.en = 1'b1;
                burst_step   = !wb_tail;
                buf_capture  = wb_tail || (burst_count != '0);
            end
            wb_send: begin
                burst_step = mem_ready;
            end
            fill: begin
                data_port.en     = mem_ready;
                data_port.strobe = '1;
                burst_step       = mem_ready;
            end
        endcase
    end

    assign burst_clear = (state == idle);
    assign addr_ok     = lk_hit;
    assign rdata       = data_port.rdata;
    assign meta_touch  = lk_hit;
    assign write_hit   = |lk_strobe;
    assign meta_fill   = (state == fill) && mem_ready && mem_last;

    assign mem_valid    = (state == wb_send) || (state == fill);
    assign mem_is_write = (state == wb_send);
    assign mem_wdata    = buf_word;

    // bursts always start at word 0 of the line
    always_comb begin
        mem_addr        = lk_addr;
        mem_addr.offset = '0;
        mem_addr.align  = '0;
        if (state == wb_send) begin
            mem_addr.tag = victim_tag;
        end
    end

    assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !(mem_ready && mem_last) |=> mem_valid && $stable(mem_addr));

    assert property (@(posedge clk) disable iff (resetn)
        addr_ok |=> data_ok && !addr_ok);

endmodule

`default_nettype wire

// File: dcache/dcache_data.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_data import dcache_pkg::*; (
    input  logic        clk,
    data_port_if.ram    data_port,
    input  logic        buf_capture,
    input  offset_t     buf_index,
    output word_t       buf_word
);

    word_t   mem [num_ways*num_sets*words_per_line];
    word_t   line_buf [words_per_line];
    offset_t rd_offset;

    // read returns the old word, writes are byte masked
    always_ff @(posedge clk) begin
        if (data_port.en) begin
            for (int b = 0; b < bytes_per_word; b++) begin
                if (data_port.strobe[b]) begin
                    mem[data_port.addr][b*byte_width +: byte_width] <=
                        data_port.wdata[b*byte_width +: byte_width];
                end
            end
            data_port.rdata <= mem[data_port.addr];
            rd_offset       <= data_port.addr.offset;
        end
    end

    // victim line copy, one word behind the array read
    always_ff @(posedge clk) begin
        if (buf_capture) begin
            line_buf[rd_offset] <= data_port.rdata;
        end
    end

    // held steady while the bus stalls
    assign buf_word = line_buf[buf_index];

endmodule

`default_nettype wire

// File: dcache/dcache_tags.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_tags import dcache_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  addr_t req_addr,
    input  logic  lookup_en,
    input  logic  meta_fill,
    input  logic  meta_touch,
    input  logic  write_hit,
    output logic  hit,
    output way_t  hit_way,
    output way_t  victim_way,
    output logic  victim_dirty,
    output tag_t  victim_tag
);

    tag_t                               tag_mem [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0]  valid;
    logic [num_ways-1:0][num_sets-1:0]  dirty;
    logic [num_sets-1:0]                plru;

    index_t              lk_index;
    tag_t                lk_tag;
    logic [num_ways-1:0] way_hit;
    way_t                sel_way;
    way_t                pick;

    always_comb begin
        sel_way = '0;
        pick    = way_t'(plru[req_addr.index]);
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid[w][req_addr.index] &&
                         (tag_mem[w][req_addr.index] == req_addr.tag);
            if (way_hit[w]) begin
                sel_way = way_t'(w);
            end
        end
        // an empty way beats the lru choice, lowest first
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid[w][req_addr.index]) begin
                pick = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            lk_index     <= req_addr.index;
            lk_tag       <= req_addr.tag;
            hit          <= |way_hit;
            hit_way      <= sel_way;
            victim_way   <= pick;
            victim_dirty <= valid[pick][req_addr.index] && dirty[pick][req_addr.index];
            victim_tag   <= tag_mem[pick][req_addr.index];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
            dirty <= '0;
            plru  <= '0;
        end else if (meta_fill) begin
            valid[victim_way][lk_index] <= 1'b1;
            dirty[victim_way][lk_index] <= 1'b0;
        end else if (meta_touch) begin
            plru[lk_index] <= ~hit_way;
            if (write_hit) begin
                dirty[hit_way][lk_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (meta_fill) begin
            tag_mem[victim_way][lk_index] <= lk_tag;
        end
    end

    // a refill must never install a tag that is already present
    assert property (@(posedge clk) disable iff (resetn)
        lookup_en |-> $onehot0(way_hit));

endmodule

`default_nettype wire

// File: hw/burst_counter.sv
`timescale 1ns/10ps
`default_nettype none

module burst_counter import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    clear,
    input  logic    step,
    output offset_t count,
    output logic    last
);

    always_ff @(posedge clk) begin
        if (resetn) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            // wraps back to word 0 after the final beat
            count <= count + 1'b1;
        end
    end

    assign last = step && (count == offset_t'(words_per_line - 1));

endmodule

`default_nettype wire

// File: hw/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    req_valid,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    mem_valid,
    output logic    mem_is_write,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  logic    mem_ready,
    input  logic    mem_last,
    input  word_t   mem_rdata
);

    logic    hit;
    way_t    hit_way;
    way_t    victim_way;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    meta_fill;
    logic    meta_touch;
    logic    write_hit;
    logic    lookup_en;
    logic    burst_step;
    logic    burst_clear;
    offset_t burst_count;
    logic    burst_last;
    logic    buf_capture;
    word_t   buf_word;

    data_port_if i_data_port ();

    dcache_ctrl i_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_wdata    (req_wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .meta_fill    (meta_fill),
        .meta_touch   (meta_touch),
        .write_hit    (write_hit),
        .lookup_en    (lookup_en),
        .burst_step   (burst_step),
        .burst_clear  (burst_clear),
        .burst_count  (burst_count),
        .burst_last   (burst_last),
        .buf_capture  (buf_capture),
        .buf_word     (buf_word),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .data_port    (i_data_port)
    );

    dcache_tags i_tags (
        .clk          (clk),
        .resetn       (resetn),
        .req_addr     (req_addr),
        .lookup_en    (lookup_en),
        .meta_fill    (meta_fill),
        .meta_touch   (meta_touch),
        .write_hit    (write_hit),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data i_data (
        .clk         (clk),
        .data_port   (i_data_port),
        .buf_capture (buf_capture),
        .buf_index   (burst_count),
        .buf_word    (buf_word)
    );

    burst_counter i_burst (
        .clk    (clk),
        .resetn (resetn),
        .clear  (burst_clear),
        .step   (burst_step),
        .count  (burst_count),
        .last   (burst_last)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_dcache -f vlog.f -o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model import dcache_pkg::*; #(
    parameter logic [31:0] pattern = '0
) (
    input  logic  clk,
    input  logic  resetn,
    input  logic  gap,
    input  logic  mem_valid,
    input  logic  mem_is_write,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    output logic  mem_ready,
    output logic  mem_last,
    output word_t mem_rdata,
    output int    rd_bursts,
    output int    wr_bursts
);

    word_t   store [logic [31:0]];
    offset_t beat = '0;
    logic    ready_q = 1'b0;
    word_t   rdata_q = '0;

    function automatic logic [31:0] beat_addr(input offset_t o);
        return {mem_addr.tag, mem_addr.index, o, 2'b00};
    endfunction

    // words never written back follow the address rule
    function automatic word_t word_at(input logic [31:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        return a ^ pattern;
    endfunction

    always @(posedge clk) begin
        if (resetn) begin
            beat      <= '0;
            ready_q   <= 1'b0;
            rd_bursts <= 0;
            wr_bursts <= 0;
        end else if (mem_valid && ready_q) begin
            if (mem_is_write) begin
                store[beat_addr(beat)] = mem_wdata;
            end
            if (mem_last) begin
                // one quiet cycle so the next burst sees its own address
                beat    <= '0;
                ready_q <= 1'b0;
                if (mem_is_write) begin
                    wr_bursts <= wr_bursts + 1;
                end else begin
                    rd_bursts <= rd_bursts + 1;
                end
            end else begin
                beat    <= beat + 1'b1;
                ready_q <= !gap;
                rdata_q <= word_at(beat_addr(beat + 1'b1));
            end
        end else begin
            ready_q <= mem_valid && !gap;
            rdata_q <= word_at(beat_addr(beat));
        end
    end

    assign mem_ready = ready_q;
    assign mem_rdata = rdata_q;
    assign mem_last  = ready_q && (beat == offset_t'(words_per_line - 1));

endmodule

`default_nettype wire

// File: test/tb_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();

    localparam logic [31:0] mem_pattern = 32'h5a3c_96e1;
    localparam logic [31:0] lfsr_seed   = 32'h02a5_20d4;
    localparam int          wait_limit  = 1000;

    logic    clk;
    logic    resetn;
    logic    req_valid;
    addr_t   req_addr;
    strobe_t req_strobe;
    word_t   req_wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    mem_valid;
    logic    mem_is_write;
    addr_t   mem_addr;
    word_t   mem_wdata;
    logic    mem_ready;
    logic    mem_last;
    word_t   mem_rdata;
    int      rd_bursts;
    int      wr_bursts;

    logic        gap = 1'b0;
    logic [31:0] gap_lfsr = lfsr_seed;
    logic [31:0] stim_lfsr = lfsr_seed;
    word_t       ref_mem [logic [31:0]];
    logic        timed_out = 1'b0;
    int          tests = 0;
    int          checks = 0;
    int          errors = 0;

    dcache_top i_dcache_top (
        .clk          (clk),
        .resetn       (resetn),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_strobe   (req_strobe),
        .req_wdata    (req_wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata)
    );

    mem_model #(.pattern(mem_pattern)) i_mem (
        .clk          (clk),
        .resetn       (resetn),
        .gap          (gap),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_last     (mem_last),
        .mem_rdata    (mem_rdata),
        .rd_bursts    (rd_bursts),
        .wr_bursts    (wr_bursts)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return v;
    endfunction

    // ready gaps for the memory model
    always @(posedge clk) begin
        gap      <= gap_lfsr[0];
        gap_lfsr <= lfsr_step(gap_lfsr);
    end

    function automatic logic [31:0] make_addr(input tag_t t, input index_t i, input offset_t o);
        addr_t a;
        a.tag    = t;
        a.index  = i;
        a.offset = o;
        a.align  = '0;
        return a;
    endfunction

    function automatic word_t ref_value(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ mem_pattern;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t d, input strobe_t s);
        word_t m;
        m = old;
        for (int b = 0; b < bytes_per_word; b++) begin
            if (s[b]) begin
                m[b*byte_width +: byte_width] = d[b*byte_width +: byte_width];
            end
        end
        return m;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    // every burst starts at word 0 of its line
    always @(negedge clk) begin
        if (mem_valid && {mem_addr.offset, mem_addr.align} != '0) begin
            report_value("mem_addr offset", 32'({mem_addr.offset, mem_addr.align}), 32'd0);
        end
    end

    task automatic end_test(input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - e0);
        end
    endtask

    // one request, held until addr_ok, then data_ok one cycle later
    task automatic access(input logic [31:0] a, input strobe_t s, input word_t d,
                          output word_t q);
        int n;
        q = '0;
        if (!timed_out) begin
            @(posedge clk);
            req_valid  <= 1'b1;
            req_addr   <= a;
            req_strobe <= s;
            req_wdata  <= d;
            n = 0;
            @(negedge clk);
            while (!addr_ok && n < wait_limit) begin
                @(negedge clk);
                n++;
            end
            if (!addr_ok) begin
                $display("timeout: no addr_ok for address %h after %0d cycles", a, n);
                timed_out = 1'b1;
                errors++;
            end
            @(posedge clk);
            req_valid <= 1'b0;
            @(negedge clk);
            checks++;
            if (!timed_out && !data_ok) begin
                report_value("data_ok", 32'(data_ok), 32'd1);
            end
            q = rdata;
        end
    endtask

    task automatic read_word(input logic [31:0] a);
        word_t q;
        access(a, '0, '0, q);
        checks++;
        if (!timed_out && q !== ref_value(a)) begin
            report_value("rdata", q, ref_value(a));
        end
    endtask

    task automatic write_word(input logic [31:0] a, input strobe_t s, input word_t d);
        word_t q;
        access(a, s, d, q);
        ref_mem[a] = merge_bytes(ref_value(a), d, s);
    endtask

    task automatic check_bursts(input int rd0, input int wr0, input int rd_n, input int wr_n);
        checks++;
        if (rd_bursts - rd0 != rd_n) begin
            report_value("read bursts", rd_bursts - rd0, rd_n);
        end
        if (wr_bursts - wr0 != wr_n) begin
            report_value("write bursts", wr_bursts - wr0, wr_n);
        end
    endtask

    task automatic check_idle_outputs();
        checks++;
        if (addr_ok) begin
            report_value("addr_ok", 32'(addr_ok), 32'd0);
        end
        if (data_ok) begin
            report_value("data_ok", 32'(data_ok), 32'd0);
        end
        if (mem_valid) begin
            report_value("mem_valid", 32'(mem_valid), 32'd0);
        end
    endtask

    task automatic check_reset_state();
        int e0;
        int rd0;
        int wr0;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        check_idle_outputs();
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        read_word(make_addr(19'd1, 7'd3, 4'd2));
        check_bursts(rd0, wr0, 1, 0);
        end_test("reset state", e0);
    endtask

    task automatic hit_without_traffic();
        int e0;
        int rd0;
        int wr0;
        e0 = errors;
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        read_word(make_addr(19'd1, 7'd3, 4'd7));
        read_word(make_addr(19'd1, 7'd3, 4'd15));
        check_bursts(rd0, wr0, 0, 0);
        end_test("hit without traffic", e0);
    endtask

    task automatic byte_strobe_write();
        int e0;
        int rd0;
        int wr0;
        logic [31:0] a;
        e0 = errors;
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        a = make_addr(19'd1, 7'd3, 4'd2);
        write_word(a, 4'b0101, 32'hdead_beef);
        read_word(a);
        write_word(a, 4'b1000, 32'h1200_0000);
        read_word(a);
        check_bursts(rd0, wr0, 0, 0);
        end_test("byte strobe write", e0);
    endtask

    task automatic dirty_eviction();
        int e0;
        int rd0;
        int wr0;
        e0 = errors;
        write_word(make_addr(19'd5, 7'd20, 4'd3), 4'b1111, 32'hcafe_0003);
        write_word(make_addr(19'd5, 7'd20, 4'd9), 4'b0011, 32'h0000_9999);
        read_word(make_addr(19'd6, 7'd20, 4'd0));
        // tag 5 is now least recent and dirty
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        read_word(make_addr(19'd7, 7'd20, 4'd0));
        check_bursts(rd0, wr0, 1, 1);
        // refetch the written-back line and evict clean tag 6
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        for (int w = 0; w < words_per_line; w++) begin
            read_word(make_addr(19'd5, 7'd20, offset_t'(w)));
        end
        check_bursts(rd0, wr0, 1, 0);
        end_test("dirty eviction", e0);
    endtask

    task automatic plru_replacement();
        int e0;
        int rd0;
        int wr0;
        e0 = errors;
        read_word(make_addr(19'd8, 7'd40, 4'd0));
        read_word(make_addr(19'd9, 7'd40, 4'd0));
        read_word(make_addr(19'd8, 7'd40, 4'd1));
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        read_word(make_addr(19'd10, 7'd40, 4'd0));
        check_bursts(rd0, wr0, 1, 0);
        rd0 = rd_bursts;
        read_word(make_addr(19'd8, 7'd40, 4'd2));
        check_bursts(rd0, wr0, 0, 0);
        read_word(make_addr(19'd9, 7'd40, 4'd3));
        check_bursts(rd0, wr0, 1, 0);
        end_test("pseudo-lru", e0);
    endtask

    task automatic random_sequence();
        int          e0;
        logic [31:0] a;
        strobe_t     s;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            // four tags over two sets keeps evictions frequent
            a = make_addr(tag_t'(rand_bits(2) + 32'd16), index_t'(rand_bits(1) + 32'd100),
                          offset_t'(rand_bits(4)));
            if (rand_bits(1) == 32'd1) begin
                s = strobe_t'(rand_bits(4));
                if (s == '0) begin
                    s = 4'b1111;
                end
                write_word(a, s, rand_bits(32));
            end else begin
                read_word(a);
            end
        end
        end_test("random sequence", e0);
    endtask

    initial begin
        clk        = 1'b0;
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_strobe = '0;
        req_wdata  = '0;
        check_reset_state();
        hit_without_traffic();
        byte_strobe_write();
        dirty_eviction();
        plru_replacement();
        random_sequence();
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/dcache_pkg.sv
common/data_port_if.sv
hw/burst_counter.sv
dcache/dcache_data.sv
dcache/dcache_tags.sv
dcache/dcache_ctrl.sv
hw/dcache_top.sv
test/mem_model.sv
test/tb_dcache.sv
